//--- build.f
+incdir+hdl
hdl/i2c_pkg.sv
hdl/codec_pkg.sv
hdl/i2c_frame_tx.sv
hdl/codec_initializer.sv
hdl/codec_config_top.sv
dv/i2c_codec_model.sv
dv/codec_config_asserts.sv
dv/tb_codec_config.sv

//--- Makefile
# Verilator build and run for the codec configuration testbench

VERILATOR ?= verilator
TOP       ?= tb_codec_config
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv) $(FILELIST)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_codec_config.sv
`timescale 1ns/1ps
`include "codec_init_defs.svh"

module tb_codec_config
    import codec_pkg::*;
;

    localparam int NUM_SCEN     = 5;
    localparam int FRAME_CYCLES = (2 + 4 * 27 + 4) * `I2C_QUARTER + 8;  // start, 27 bits, stop
    localparam int MAX_CYCLES   = NUM_SCEN * `CODEC_NUM_CMDS * `CODEC_RETRY_LIMIT
                                  * FRAME_CYCLES + 2000;

    typedef struct packed {
        logic [1:0] mode;      // 0 clean, 1 refuse once, 2 refuse every attempt
        logic [3:0] idx;
        logic [1:0] byte_no;
        logic       done;
        logic       err;
        logic [7:0] frames;
        logic [7:0] refusals;
    } scen_t;

    localparam scen_t SCENARIOS [NUM_SCEN] = '{
        '{2'd0, 4'd0, 2'd0, 1'b1, 1'b0, 8'(`CODEC_NUM_CMDS), 8'd0},
        '{2'd1, 4'd3, 2'd1, 1'b1, 1'b0, 8'(`CODEC_NUM_CMDS), 8'd1},
        '{2'd1, 4'd0, 2'd0, 1'b1, 1'b0, 8'(`CODEC_NUM_CMDS), 8'd1},
        '{2'd2, 4'd5, 2'd2, 1'b0, 1'b1, 8'd5, 8'(`CODEC_RETRY_LIMIT)},
        '{2'd0, 4'd0, 2'd0, 1'b1, 1'b0, 8'(`CODEC_NUM_CMDS), 8'd0}  // replay after error
    };

    logic       i_clk;
    logic       i_rst_n;
    logic       i_start;
    logic       scl_oe;
    logic       sda_oe;
    logic       model_sda_oe;
    logic       busy;
    logic       done;
    logic       error;
    logic       clear;
    logic [1:0] refuse_mode;
    logic [3:0] refuse_idx;
    logic [1:0] refuse_byte;
    wire        scl_line = ~scl_oe;                  // pull-up, low wins
    wire        sda_line = ~(sda_oe | model_sda_oe);
    int         value_errs;
    int         other_errs;
    int         cycles;
    scen_t      sc;

    codec_config_top UUT (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_sda    (sda_line),
        .o_scl_oe (scl_oe),
        .o_sda_oe (sda_oe),
        .o_busy   (busy),
        .o_done   (done),
        .o_error  (error)
    );

    i2c_codec_model model (
        .i_scl         (scl_line),
        .i_sda         (sda_line),
        .i_clear       (clear),
        .i_refuse_mode (refuse_mode),
        .i_refuse_idx  (refuse_idx),
        .i_refuse_byte (refuse_byte),
        .o_sda_oe      (model_sda_oe)
    );

    bind codec_config_top codec_config_asserts u_asserts (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_scl_oe (o_scl_oe),
        .i_sda_oe (o_sda_oe),
        .i_req    (req),
        .i_ack    (ack),
        .i_done   (o_done),
        .i_error  (o_error)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    // hang guard
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run hung after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic expect_idle();
        compare_value("scl_line", scl_line, 1'b1);
        compare_value("sda_line", sda_line, 1'b1);
        compare_value("o_busy", busy, 1'b0);
    endtask

    task automatic audit_frames(scen_t s);
        logic [23:0] exp_word;
        compare_value("captured frames", model.n_captured, s.frames);
        compare_value("refused frames", model.n_refused, s.refusals);
        if (model.n_bad != 0) begin
            $display("frame without proper start or stop seen %0d times", model.n_bad);
            other_errs++;
        end
        for (int i = 0; i < model.n_captured && i < `CODEC_NUM_CMDS; i++) begin
            exp_word = CODEC_INIT_TABLE[i];
            compare_value("frame word", model.captured[i], exp_word);
            compare_value("address byte", model.captured[i][23:16], {`CODEC_DEV_ADDR, 1'b0});
        end
        for (int k = 0; k < model.n_refused; k++) begin
            compare_value("refused index", model.refused_at[k], s.idx);
        end
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        clear       = 1'b0;
        refuse_mode = 2'd0;
        refuse_idx  = 4'd0;
        refuse_byte = 2'd0;
        value_errs  = 0;
        other_errs  = 0;
        repeat (8) @(posedge i_clk);
        #2 i_rst_n = 1'b1;
        repeat (10) begin
            next_cycle();
            expect_idle();  // lines stay released while idle
        end

        for (int r = 0; r < NUM_SCEN; r++) begin
            sc          = SCENARIOS[r];
            refuse_mode = sc.mode;
            refuse_idx  = sc.idx;
            refuse_byte = sc.byte_no;
            clear       = 1'b1;
            next_cycle();
            clear   = 1'b0;
            i_start = 1'b1;
            next_cycle();
            i_start = 1'b0;
            while (!busy) next_cycle();
            compare_value("o_done", done, 1'b0);  // cleared by the accepted start
            compare_value("o_error", error, 1'b0);
            while (busy) next_cycle();
            compare_value("o_done", done, sc.done);
            compare_value("o_error", error, sc.err);
            audit_frames(sc);
            repeat (5) begin
                next_cycle();
                expect_idle();
            end
        end

        other_errs += UUT.u_asserts.n_fail;
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- dv/codec_config_asserts.sv
`timescale 1ns/1ps

module codec_config_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_scl_oe,
    input logic i_sda_oe,
    input logic i_req,
    input logic i_ack,
    input logic i_done,
    input logic i_error
);

    int n_fail;  // failed assertion count

    // sda moves with scl low, or as start/stop after scl has been high a while
    a_sda_scl_low : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($changed(i_sda_oe) && !i_scl_oe) |-> ($past(!i_scl_oe, 1) && $past(!i_scl_oe, 2)))
        else begin
            n_fail++;
            $error("SDA changed near an SCL edge");
        end

    a_sda_not_on_scl_edge : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $changed(i_sda_oe) |-> !$changed(i_scl_oe))
        else begin
            n_fail++;
            $error("SDA and SCL changed together");
        end

    a_ack_needs_req : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> i_req)
        else begin
            n_fail++;
            $error("ack rose without req");
        end

    a_req_held : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_req && !i_ack) |=> i_req)
        else begin
            n_fail++;
            $error("req dropped before ack");
        end

    a_flags_exclusive : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_done && i_error))
        else begin
            n_fail++;
            $error("done and error both high");
        end

endmodule

//--- dv/i2c_codec_model.sv
`timescale 1ns/1ps

module i2c_codec_model (
    input  logic       i_scl,
    input  logic       i_sda,
    input  logic       i_clear,        // clears the frame logs
    input  logic [1:0] i_refuse_mode,  // 0 never, 1 once, 2 every attempt
    input  logic [3:0] i_refuse_idx,
    input  logic [1:0] i_refuse_byte,
    output logic       o_sda_oe
);

    logic [23:0] captured [0:63];   // acknowledged frames in bus order
    int          refused_at [0:63]; // command index of each refused frame
    int          n_captured;
    int          n_refused;
    int          n_bad;             // frames without a proper start or stop
    logic        in_frame;
    logic        ack_slot;
    logic        refused;
    logic        used_once;
    int          bit_cnt;
    int          byte_cnt;
    logic [23:0] word;

    initial begin
        o_sda_oe   = 1'b0;
        in_frame   = 1'b0;
        ack_slot   = 1'b0;
        refused    = 1'b0;
        used_once  = 1'b0;
        n_captured = 0;
        n_refused  = 0;
        n_bad      = 0;
        bit_cnt    = 0;
        byte_cnt   = 0;
        word       = '0;
    end

    always @(posedge i_clear) begin
        n_captured = 0;
        n_refused  = 0;
        n_bad      = 0;
        used_once  = 1'b0;
    end

    // start condition
    always @(negedge i_sda) begin
        if (i_scl === 1'b1) begin
            if (in_frame) n_bad++;  // repeated start is never sent
            in_frame = 1'b1;
            ack_slot = 1'b0;
            refused  = 1'b0;
            bit_cnt  = 0;
            byte_cnt = 0;
            word     = '0;
        end
    end

    // stop condition
    always @(posedge i_sda) begin
        if (i_scl === 1'b1 && in_frame) begin
            in_frame = 1'b0;
            if (refused) begin
                refused_at[n_refused] = n_captured;
                n_refused++;
            end else if (byte_cnt == 3 && !ack_slot) begin
                captured[n_captured] = word;
                n_captured++;
            end else begin
                n_bad++;
            end
        end
    end

    always @(posedge i_scl) begin
        if (in_frame && !ack_slot && byte_cnt < 3) begin  // the scl pulse of a stop carries no data
            word = {word[22:0], i_sda};
            bit_cnt++;
        end
    end

    always @(negedge i_scl) begin
        if (in_frame) begin
            if (ack_slot) begin
                ack_slot = 1'b0;
                o_sda_oe = 1'b0;  // release after the ack clock
            end else if (bit_cnt == 8) begin
                bit_cnt  = 0;
                ack_slot = 1'b1;
                if (n_captured == i_refuse_idx && byte_cnt == i_refuse_byte &&
                    (i_refuse_mode == 2'd2 || (i_refuse_mode == 2'd1 && !used_once))) begin
                    refused   = 1'b1;
                    used_once = 1'b1;
                end else begin
                    o_sda_oe = 1'b1;
                end
                byte_cnt++;
            end
        end
    end

endmodule

//--- hdl/codec_config_top.sv
`timescale 1ns/1ps

module codec_config_top
    import codec_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sda,     // resolved SDA line
    output logic o_scl_oe,  // high pulls SCL low
    output logic o_sda_oe,  // high pulls SDA low
    output logic o_busy,
    output logic o_done,
    output logic o_error
);

    logic       req;
    logic       ack;
    logic       nack;
    codec_cmd_t cmd;

    codec_initializer u_init (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_ack   (ack),
        .i_nack  (nack),
        .o_req   (req),
        .o_cmd   (cmd),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .o_error (o_error)
    );

    i2c_frame_tx u_tx (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (req),
        .i_cmd    (cmd),
        .i_sda    (i_sda),
        .o_ack    (ack),
        .o_nack   (nack),
        .o_scl_oe (o_scl_oe),
        .o_sda_oe (o_sda_oe)
    );

endmodule

//--- hdl/codec_initializer.sv
`timescale 1ns/1ps
`include "codec_init_defs.svh"

module codec_initializer
    import codec_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_ack,
    input  logic       i_nack,
    output logic       o_req,
    output codec_cmd_t o_cmd,
    output logic       o_busy,
    output logic       o_done,
    output logic       o_error
);

    localparam int TRY_W = $clog2(`CODEC_RETRY_LIMIT + 1);
    localparam logic [TRY_W-1:0] TRY_LIMIT = TRY_W'(`CODEC_RETRY_LIMIT);
    localparam codec_cmd_idx_t LAST_IDX = codec_cmd_idx_t'(`CODEC_NUM_CMDS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,   // request held until the frame is acknowledged
        ST_WAIT   // request dropped, waiting for ack to fall
    } init_state_t;

    init_state_t      state_r;
    codec_cmd_idx_t   idx_r;
    logic [TRY_W-1:0] fail_r;     // failed attempts on the current command
    logic [TRY_W-1:0] fail_next;

    assign fail_next = fail_r + 1'b1;
    assign o_cmd     = CODEC_INIT_TABLE[idx_r];
    assign o_req     = (state_r == ST_REQ);
    assign o_busy    = (state_r != ST_IDLE);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= ST_IDLE;
            idx_r   <= '0;
            fail_r  <= '0;
            o_done  <= 1'b0;
            o_error <= 1'b0;
        end else begin
            case (state_r)
                ST_IDLE: begin
                    if (i_start) begin
                        state_r <= ST_REQ;
                        idx_r   <= '0;
                        fail_r  <= '0;
                        o_done  <= 1'b0;  // flags held until a new start
                        o_error <= 1'b0;
                    end
                end
                ST_REQ: begin
                    if (i_ack) begin
                        state_r <= ST_WAIT;
                        if (i_nack) begin
                            fail_r <= fail_next;
                            if (fail_next == TRY_LIMIT) begin
                                o_error <= 1'b1;  // give up, rest of table dropped
                            end
                        end else begin
                            fail_r <= '0;
                            if (idx_r == LAST_IDX) begin
                                o_done <= 1'b1;
                            end else begin
                                idx_r <= idx_r + 1'b1;
                            end
                        end
                    end
                end
                ST_WAIT: begin
                    if (!i_ack) begin
                        state_r <= (o_done || o_error) ? ST_IDLE : ST_REQ;
                    end
                end
                default: state_r <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/i2c_frame_tx.sv
`timescale 1ns/1ps
`include "codec_init_defs.svh"

module i2c_frame_tx
    import i2c_pkg::*;
    import codec_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_req,
    input  codec_cmd_t i_cmd,
    input  logic       i_sda,
    output logic       o_ack,
    output logic       o_nack,
    output logic       o_scl_oe,
    output logic       o_sda_oe
);

    localparam int QCNT_W = (`I2C_QUARTER > 1) ? $clog2(`I2C_QUARTER) : 1;
    localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(`I2C_QUARTER - 1);
    localparam i2c_byte_cnt_t LAST_BYTE = i2c_byte_cnt_t'(I2C_FRAME_BYTES - 1);

    i2c_phase_t         phase_r;
    logic [QCNT_W-1:0]  qcnt_r;      // cycles within a quarter
    logic [1:0]         qtr_r;       // quarter within a bit
    logic               tick;
    i2c_bit_cnt_t       bit_cnt_r;
    i2c_byte_cnt_t      byte_cnt_r;
    logic [23:0]        shift_r;
    logic               nack_r;
    logic               sda_want;
    logic               sda_oe_r;

    assign tick = (qcnt_r == QCNT_LAST);

    // quarter-period divider, parked while idle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            qcnt_r <= '0;
        end else if (phase_r == I2C_IDLE || phase_r == I2C_DONE || tick) begin
            qcnt_r <= '0;
        end else begin
            qcnt_r <= qcnt_r + 1'b1;
        end
    end

    // word latched on accept, shifted after every data bit
    always_ff @(posedge i_clk) begin
        if (phase_r == I2C_IDLE && i_req) begin
            shift_r <= i_cmd;
        end else if (phase_r == I2C_BIT && tick && qtr_r == 2'd3) begin
            shift_r <= {shift_r[22:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_r    <= I2C_IDLE;
            qtr_r      <= '0;
            bit_cnt_r  <= '0;
            byte_cnt_r <= '0;
            nack_r     <= 1'b0;
        end else begin
            case (phase_r)
                I2C_IDLE: begin
                    if (i_req) begin
                        phase_r <= I2C_START;
                        qtr_r   <= '0;
                        nack_r  <= 1'b0;
                    end
                end
                I2C_START: begin
                    if (tick) begin
                        if (qtr_r[0]) begin  // both halves done
                            phase_r    <= I2C_BIT;
                            qtr_r      <= '0;
                            bit_cnt_r  <= 3'd7;
                            byte_cnt_r <= '0;
                        end else begin
                            qtr_r <= qtr_r + 2'd1;
                        end
                    end
                end
                I2C_BIT: begin
                    if (tick) begin
                        qtr_r <= qtr_r + 2'd1;
                        if (qtr_r == 2'd3) begin
                            if (bit_cnt_r == '0) begin
                                phase_r <= I2C_ACK;
                            end else begin
                                bit_cnt_r <= bit_cnt_r - 1'b1;
                            end
                        end
                    end
                end
                I2C_ACK: begin
                    if (tick) begin
                        qtr_r <= qtr_r + 2'd1;
                        if (qtr_r == 2'd1 && i_sda) begin
                            nack_r <= 1'b1;  // line left high by slave
                        end
                        if (qtr_r == 2'd3) begin
                            if (nack_r || byte_cnt_r == LAST_BYTE) begin
                                phase_r <= I2C_STOP;  // refused bytes skip the rest
                            end else begin
                                phase_r    <= I2C_BIT;
                                byte_cnt_r <= byte_cnt_r + 1'b1;
                                bit_cnt_r  <= 3'd7;
                            end
                        end
                    end
                end
                I2C_STOP: begin
                    if (tick) begin
                        qtr_r <= qtr_r + 2'd1;
                        if (qtr_r == 2'd3) begin
                            phase_r <= I2C_DONE;
                        end
                    end
                end
                I2C_DONE: begin
                    if (!i_req) begin
                        phase_r <= I2C_IDLE;
                    end
                end
                default: phase_r <= I2C_IDLE;
            endcase
        end
    end

    // SCL low in quarters 0 and 3 of a bit
    always_comb begin
        o_scl_oe = 1'b0;
        sda_want = 1'b0;
        case (phase_r)
            I2C_START: sda_want = qtr_r[0];
            I2C_BIT: begin
                o_scl_oe = (qtr_r == 2'd0) || (qtr_r == 2'd3);
                sda_want = ~shift_r[23];
            end
            I2C_ACK:  o_scl_oe = (qtr_r == 2'd0) || (qtr_r == 2'd3);  // SDA released
            I2C_STOP: begin
                o_scl_oe = (qtr_r == 2'd0);
                sda_want = (qtr_r <= 2'd1);  // released in quarter 2 while SCL high
            end
            default: ;
        endcase
    end

    // one cycle behind SCL so data never moves on an SCL edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sda_oe_r <= 1'b0;
        end else begin
            sda_oe_r <= sda_want;
        end
    end

    assign o_sda_oe = sda_oe_r;
    assign o_ack    = (phase_r == I2C_DONE);
    assign o_nack   = nack_r;

endmodule

//--- hdl/codec_pkg.sv
`include "codec_init_defs.svh"

package codec_pkg;

    // one register write, sent MSB first as three bytes
    typedef struct packed {
        logic [6:0] dev_addr;  // 7-bit slave address
        logic       rw;        // 0 for write
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } codec_cmd_t;

    typedef logic [3:0] codec_cmd_idx_t;

    function automatic codec_cmd_t codec_write(logic [6:0] reg_addr, logic [8:0] reg_data);
        codec_cmd_t cmd;
        cmd.dev_addr = `CODEC_DEV_ADDR;
        cmd.rw       = 1'b0;
        cmd.reg_addr = reg_addr;
        cmd.reg_data = reg_data;
        return cmd;
    endfunction

    // bring-up sequence, sent in index order
    localparam codec_cmd_t CODEC_INIT_TABLE [`CODEC_NUM_CMDS] = '{
        codec_write(7'h00, 9'h097),  // left line in
        codec_write(7'h01, 9'h097),  // right line in
        codec_write(7'h02, 9'h079),  // left headphone out
        codec_write(7'h03, 9'h079),  // right headphone out
        codec_write(7'h04, 9'h015),  // analogue path, dac selected
        codec_write(7'h05, 9'h000),  // digital path
        codec_write(7'h06, 9'h000),  // power down, all on
        codec_write(7'h07, 9'h042),  // interface format, master, i2s
        codec_write(7'h08, 9'h019),  // sampling control
        codec_write(7'h09, 9'h001),  // activate interface
        codec_write(7'h0F, 9'h000)   // reset register
    };

endpackage

//--- hdl/i2c_pkg.sv
package i2c_pkg;

    // frame transmitter phases
    typedef enum logic [2:0] {
        I2C_IDLE,   // lines released, waiting for a request
        I2C_START,  // two quarters: SDA falls while SCL high
        I2C_BIT,    // one data bit, four quarters
        I2C_ACK,    // slave acknowledge slot
        I2C_STOP,   // SDA rises while SCL high
        I2C_DONE    // ack raised, waiting for req to drop
    } i2c_phase_t;

    // device address byte plus two payload bytes
    localparam int I2C_FRAME_BYTES = 3;

    // bit position within a byte, counts down from 7
    typedef logic [2:0] i2c_bit_cnt_t;

    // byte position within a frame
    typedef logic [1:0] i2c_byte_cnt_t;

endpackage

//--- hdl/codec_init_defs.svh
`ifndef CODEC_INIT_DEFS_SVH
`define CODEC_INIT_DEFS_SVH

// bus timing
// clock cycles per quarter of an SCL period
`define I2C_QUARTER 4

// command table
`define CODEC_NUM_CMDS 11

// attempts per command before the sequence gives up
`define CODEC_RETRY_LIMIT 3

// codec slave address, CSB tied low
`define CODEC_DEV_ADDR 7'b0011010

`endif
